// ==== compile.f ====
+incdir+logic
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/alu_frame_ctrl.sv
logic/uart_alu_top.sv
testbench/tb_uart_alu.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_uart_alu
FILELIST  := compile.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes.
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_uart_alu.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "uart_defines.svh"

module tb_uart_alu;

    localparam int W          = `UART_WORD_WIDTH;
    localparam int BIT_CLOCKS = `UART_TICKS_PER_BIT * `UART_BAUD_DIVISOR;
    localparam int FRAME_BITS = 1 + `UART_WORD_WIDTH + `UART_STOP_BITS;
    localparam int REPLY_WAIT = 5 * FRAME_BITS * BIT_CLOCKS;   // Three requests and a reply.

    // Sweep, random, unknown, framing and two glitch commands.
    localparam int COMMANDS       = 8 + 16 + 1 + 1 + 2;
    localparam int FRAMES         = 4 * COMMANDS + 4;
    localparam int TIMEOUT_CYCLES = FRAMES * FRAME_BITS * BIT_CLOCKS * 2;

    localparam uart_pkg::alu_op_t OPCODES [8] = '{
        uart_pkg::OP_ADD, uart_pkg::OP_SUB, uart_pkg::OP_AND, uart_pkg::OP_OR,
        uart_pkg::OP_XOR, uart_pkg::OP_NOR, uart_pkg::OP_SRA, uart_pkg::OP_SRL
    };

    logic i_clock = 1'b0;
    logic i_reset = 1'b0;
    logic i_rx    = 1'b1;   // Line idles high.
    logic o_tx;
    logic o_rx_error;

    int error_count     = 0;
    int check_count     = 0;
    int tests_run       = 0;
    int cycle_count     = 0;
    int rx_error_pulses = 0;
    int seed            = 32'hef1a;

    logic [W-1:0] reply_data;
    logic         reply_seen;

    uart_alu_top i_uart_alu_top (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx       (i_rx),
        .o_tx       (o_tx),
        .o_rx_error (o_rx_error)
    );

    always #5 i_clock = ~i_clock;

    always @(negedge i_clock) begin
        if (o_rx_error) rx_error_pulses <= rx_error_pulses + 1;
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model and compares.
    ////////////////////////////////////////////////////////////

    function automatic logic [W-1:0] expected_result(input logic [W-1:0] a, b, op);
        logic [2*W-1:0] extended;
        int             shift;
        shift    = int'(b) % W;
        extended = {{W{a[W-1]}}, a} >> shift;   // Sign fill from the top.
        case (op[5:0])
            uart_pkg::OP_ADD: return a + b;
            uart_pkg::OP_SUB: return a - b;
            uart_pkg::OP_AND: return a & b;
            uart_pkg::OP_OR:  return a | b;
            uart_pkg::OP_XOR: return a ^ b;
            uart_pkg::OP_NOR: return ~(a | b);
            uart_pkg::OP_SRA: return extended[W-1:0];
            uart_pkg::OP_SRL: return a >> shift;
            default:          return '0;
        endcase
    endfunction

    task automatic compare_byte(input logic [W-1:0] got, expected, input string what);
        check_count++;
        if (got !== expected) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_bit(input logic got, expected, input string what);
        check_count++;
        if (got !== expected) begin
            $display("Fail at %0t ns: %s, got %b, expected %b", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Serial driver and monitor.
    ////////////////////////////////////////////////////////////

    task automatic idle_line(input int cycles);
        repeat (cycles) begin
            @(posedge i_clock);
            i_rx <= 1'b1;
        end
    endtask

    // Start bit, data LSB first, then stop bits.
    task automatic send_byte(input logic [W-1:0] data, input logic bad_stop);
        logic [FRAME_BITS-1:0] frame;
        frame        = '1;
        frame[0]     = 1'b0;
        frame[W:1]   = data;
        if (bad_stop) frame[FRAME_BITS-1] = 1'b0;
        for (int i = 0; i < FRAME_BITS; i++) begin
            repeat (BIT_CLOCKS) begin
                @(posedge i_clock);
                i_rx <= frame[i];
            end
        end
        @(posedge i_clock);
        i_rx <= 1'b1;   // Ends the last stop bit on time.
    endtask

    task automatic recv_byte(output logic [W-1:0] data, output logic got_frame);
        logic [FRAME_BITS-1:0] frame;
        int                    waited;
        waited    = 0;
        got_frame = 1'b0;
        data      = '0;
        do begin
            @(negedge i_clock);
            waited++;
        end while (o_tx !== 1'b0 && waited < REPLY_WAIT);
        if (o_tx !== 1'b0) begin
            $display("No reply frame arrived within %0d cycles at %0t ns", waited, $time);
            error_count++;
        end else begin
            repeat (BIT_CLOCKS / 2) @(negedge i_clock);
            frame[0] = o_tx;   // Start bit centre.
            for (int i = 1; i < FRAME_BITS; i++) begin
                repeat (BIT_CLOCKS) @(negedge i_clock);
                frame[i] = o_tx;
            end
            compare_bit(frame[0], 1'b0, "reply start bit");
            for (int i = W + 1; i < FRAME_BITS; i++) begin
                compare_bit(frame[i], 1'b1, "reply stop bit");
            end
            data      = frame[W:1];
            got_frame = 1'b1;
        end
    endtask

    // Three request bytes out while the reply is watched.
    task automatic run_command(input logic [W-1:0] a, b, op);
        fork
            begin
                send_byte(a, 1'b0);
                send_byte(b, 1'b0);
                send_byte(op, 1'b0);
            end
            recv_byte(reply_data, reply_seen);
        join
        if (reply_seen) begin
            compare_byte(reply_data, expected_result(a, b, op),
                $sformatf("result of %h op %h on %h", a, op, b));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests.
    ////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        int errors_before;
        errors_before = error_count;
        repeat (200) begin
            @(negedge i_clock);
            compare_bit(o_tx, 1'b1, "idle tx line");
            compare_bit(o_rx_error, 1'b0, "idle error flag");
        end
        report_test("idle line after reset", errors_before);
    endtask

    task automatic opcode_sweep();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            run_command(8'hc5, 8'h03, {2'b00, OPCODES[i]});
        end
        report_test("each opcode", errors_before);
    endtask

    task automatic random_operands();
        int          errors_before;
        logic [31:0] rnd;
        errors_before = error_count;
        repeat (16) begin
            rnd = $random(seed);
            // Upper opcode bits are random and must be ignored.
            run_command(rnd[W-1:0], rnd[2*W-1:W], {rnd[31:30], OPCODES[rnd[18:16]]});
        end
        report_test("random operands", errors_before);
    endtask

    task automatic unknown_opcode();
        int errors_before;
        errors_before = error_count;
        run_command(8'h5a, 8'h33, 8'h3f);
        report_test("unknown opcode", errors_before);
    endtask

    task automatic framing_error_recovery();
        int errors_before;
        int pulses_before;
        errors_before = error_count;
        pulses_before = rx_error_pulses;
        send_byte(8'h77, 1'b1);
        idle_line(2 * BIT_CLOCKS);   // Receiver needs a high bit to recover.
        compare_bit(rx_error_pulses == pulses_before + 1, 1'b1, "one framing error pulse");
        run_command(8'h21, 8'h14, {2'b00, uart_pkg::OP_SUB});
        compare_bit(rx_error_pulses == pulses_before + 1, 1'b1, "no error on good frames");
        report_test("framing error", errors_before);
    endtask

    task automatic start_glitch_rejected();
        int   errors_before;
        int   pulses_before;
        logic line_dropped;
        errors_before = error_count;
        pulses_before = rx_error_pulses;
        line_dropped  = 1'b0;
        // Operands go first, leaving the controller waiting for an opcode.
        send_byte(8'h9c, 1'b0);
        send_byte(8'h05, 1'b0);
        repeat (BIT_CLOCKS / 4) begin
            @(posedge i_clock);
            i_rx <= 1'b0;
        end
        @(posedge i_clock);
        i_rx <= 1'b1;
        repeat (2 * FRAME_BITS * BIT_CLOCKS) begin
            @(negedge i_clock);
            if (o_tx !== 1'b1) line_dropped = 1'b1;
        end
        compare_bit(line_dropped, 1'b0, "no reply after glitch");
        compare_bit(rx_error_pulses == pulses_before, 1'b1, "no error after glitch");
        fork
            send_byte({2'b00, uart_pkg::OP_SRA}, 1'b0);
            recv_byte(reply_data, reply_seen);
        join
        if (reply_seen) begin
            compare_byte(reply_data, expected_result(8'h9c, 8'h05, {2'b00, uart_pkg::OP_SRA}),
                "result of the command around the glitch");
        end
        run_command(8'h9c, 8'h05, {2'b00, uart_pkg::OP_SRA});
        report_test("start glitch", errors_before);
    endtask

    initial begin
        repeat (2) @(posedge i_clock);
        i_reset <= 1'b1;
        idle_after_reset();
        opcode_sweep();
        random_operands();
        unknown_opcode();
        framing_error_recovery();
        start_glitch_rejected();
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count,
            error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/uart_alu_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "uart_defines.svh"

module uart_alu_top (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx,
    output logic o_tx,
    output logic o_rx_error
);

    logic                        tick;      // Shared by both directions.
    logic [`UART_WORD_WIDTH-1:0] rx_data;
    logic                        rx_done;
    logic [`UART_WORD_WIDTH-1:0] tx_data;
    logic                        tx_start;
    logic                        tx_busy;

    baud_tick_gen i_baud_tick_gen (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx i_uart_rx (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rx    (i_rx),
        .o_data  (rx_data),
        .o_done  (rx_done),
        .o_error (o_rx_error)
    );

    alu_frame_ctrl i_alu_frame_ctrl (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_data  (rx_data),
        .i_rx_done  (rx_done),
        .i_tx_busy  (tx_busy),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start)
    );

    uart_tx i_uart_tx (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_tx    (o_tx),
        .o_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// ==== logic/alu_frame_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "uart_defines.svh"

module alu_frame_ctrl (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic [`UART_WORD_WIDTH-1:0] i_rx_data,
    input  logic                        i_rx_done,
    input  logic                        i_tx_busy,
    output logic [`UART_WORD_WIDTH-1:0] o_tx_data,
    output logic                        o_tx_start
);

    localparam int SHIFT_W = $clog2(`UART_WORD_WIDTH);
    localparam int OP_W    = $bits(uart_pkg::alu_op_t);

    uart_pkg::ctrl_state_t state;
    uart_pkg::alu_op_t     alu_op;

    logic [`UART_WORD_WIDTH-1:0] operand_a;
    logic [`UART_WORD_WIDTH-1:0] operand_b;
    logic [`UART_WORD_WIDTH-1:0] alu_result;
    logic [SHIFT_W-1:0]          shift_amt;

    ////////////////////////////////////////////////////////////
    // ALU, fed straight from the opcode byte.
    ////////////////////////////////////////////////////////////

    assign alu_op    = uart_pkg::alu_op_t'(i_rx_data[OP_W-1:0]);   // Top bits ignored.
    assign shift_amt = operand_b[SHIFT_W-1:0];                    // B modulo word width.

    always_comb begin
        case (alu_op)
            uart_pkg::OP_ADD: alu_result = operand_a + operand_b;
            uart_pkg::OP_SUB: alu_result = operand_a - operand_b;
            uart_pkg::OP_AND: alu_result = operand_a & operand_b;
            uart_pkg::OP_OR:  alu_result = operand_a | operand_b;
            uart_pkg::OP_XOR: alu_result = operand_a ^ operand_b;
            uart_pkg::OP_NOR: alu_result = ~(operand_a | operand_b);
            uart_pkg::OP_SRA: alu_result = $unsigned($signed(operand_a) >>> shift_amt);
            uart_pkg::OP_SRL: alu_result = operand_a >> shift_amt;
            default:          alu_result = '0;   // Unknown opcode.
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Frame sequencing.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state <= uart_pkg::CTRL_GET_A;
        end else begin
            case (state)
                uart_pkg::CTRL_GET_A: begin
                    if (i_rx_done) state <= uart_pkg::CTRL_GET_B;
                end
                uart_pkg::CTRL_GET_B: begin
                    if (i_rx_done) state <= uart_pkg::CTRL_GET_OP;
                end
                uart_pkg::CTRL_GET_OP: begin
                    if (i_rx_done) state <= uart_pkg::CTRL_SEND;
                end
                uart_pkg::CTRL_SEND: begin
                    // Bytes arriving here are dropped.
                    if (!i_tx_busy) state <= uart_pkg::CTRL_GET_A;
                end
                default: state <= uart_pkg::CTRL_GET_A;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rx_done && state == uart_pkg::CTRL_GET_A) begin
            operand_a <= i_rx_data;
        end
        if (i_rx_done && state == uart_pkg::CTRL_GET_B) begin
            operand_b <= i_rx_data;
        end
        if (i_rx_done && state == uart_pkg::CTRL_GET_OP) begin
            o_tx_data <= alu_result;   // Result held through the reply.
        end
    end

    assign o_tx_start = (state == uart_pkg::CTRL_SEND) && !i_tx_busy;

    // Start only into an idle transmitter, which then reports busy.
    a_start_handshake : assert property (@(posedge i_clock) disable iff (!i_reset)
        o_tx_start |-> !i_tx_busy ##1 i_tx_busy)
        else $error("transmit start while busy or not acknowledged");

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "uart_defines.svh"

module uart_tx (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_tick,
    input  logic                        i_start,
    input  logic [`UART_WORD_WIDTH-1:0] i_data,
    output logic                        o_tx,
    output logic                        o_busy
);

    localparam int TICK_W = $clog2(`UART_TICKS_PER_BIT);
    localparam int BIT_W  = $clog2(`UART_WORD_WIDTH + 1);
    localparam int STOP_W = $clog2(`UART_STOP_BITS + 1);

    localparam logic [TICK_W-1:0] BIT_LAST  = TICK_W'(`UART_TICKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0]  WORD_LAST = BIT_W'(`UART_WORD_WIDTH - 1);
    localparam logic [STOP_W-1:0] STOP_LAST = STOP_W'(`UART_STOP_BITS - 1);

    uart_pkg::tx_state_t state;

    logic [TICK_W-1:0]           tick_cnt;
    logic [BIT_W-1:0]            bit_cnt;
    logic [STOP_W-1:0]           stop_cnt;
    logic [`UART_WORD_WIDTH-1:0] shift_reg;
    logic                        bit_end;

    assign bit_end = i_tick && (tick_cnt == BIT_LAST);

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state    <= uart_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            stop_cnt <= '0;
            o_tx     <= 1'b1;   // Line idles high.
            o_busy   <= 1'b0;
        end else if (state == uart_pkg::TX_IDLE) begin
            if (i_start) begin
                state    <= uart_pkg::TX_START;
                tick_cnt <= '0;
                o_tx     <= 1'b0;   // Start bit.
                o_busy   <= 1'b1;
            end
        end else if (i_tick) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            case (state)
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_cnt <= '0;
                        o_tx    <= shift_reg[0];
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == WORD_LAST) begin
                            state    <= uart_pkg::TX_STOP;
                            stop_cnt <= '0;
                            o_tx     <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            o_tx    <= shift_reg[1];   // Next bit after the shift.
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_end) begin
                        if (stop_cnt == STOP_LAST) begin
                            state  <= uart_pkg::TX_IDLE;
                            o_busy <= 1'b0;
                        end else begin
                            stop_cnt <= stop_cnt + 1'b1;
                        end
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Payload latched on start, shifted down one bit per data bit.
    always_ff @(posedge i_clock) begin
        if (state == uart_pkg::TX_IDLE && i_start) begin
            shift_reg <= i_data;
        end else if (state == uart_pkg::TX_DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    a_idle_high : assert property (@(posedge i_clock) disable iff (!i_reset)
        (state == uart_pkg::TX_IDLE) |-> o_tx)
        else $error("transmit line low while idle");

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "uart_defines.svh"

module uart_rx (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_tick,
    input  logic                        i_rx,
    output logic [`UART_WORD_WIDTH-1:0] o_data,
    output logic                        o_done,
    output logic                        o_error
);

    localparam int TICK_W = $clog2(`UART_TICKS_PER_BIT);
    localparam int BIT_W  = $clog2(`UART_WORD_WIDTH + 1);
    localparam int STOP_W = $clog2(`UART_STOP_BITS + 1);

    localparam logic [TICK_W-1:0] HALF_LAST = TICK_W'(`UART_TICKS_PER_BIT / 2 - 1);
    localparam logic [TICK_W-1:0] BIT_LAST  = TICK_W'(`UART_TICKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0]  WORD_LAST = BIT_W'(`UART_WORD_WIDTH - 1);
    localparam logic [STOP_W-1:0] STOP_LAST = STOP_W'(`UART_STOP_BITS - 1);

    uart_pkg::rx_state_t state;
    uart_pkg::rx_state_t state_next;

    logic [TICK_W-1:0]           tick_cnt;
    logic [BIT_W-1:0]            bit_cnt;
    logic [STOP_W-1:0]           stop_cnt;
    logic [`UART_WORD_WIDTH-1:0] shift_reg;

    logic start_centre;   // Middle of the start bit.
    logic bit_end;        // Centre of a data or stop bit.

    assign start_centre = i_tick && (tick_cnt == HALF_LAST);
    assign bit_end      = i_tick && (tick_cnt == BIT_LAST);

    ////////////////////////////////////////////////////////////
    // Next state.
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            uart_pkg::RX_IDLE: begin
                if (i_tick && !i_rx) begin
                    state_next = uart_pkg::RX_START;   // Falling edge seen.
                end
            end
            uart_pkg::RX_START: begin
                if (start_centre) begin
                    // Line back high at the centre means a glitch.
                    state_next = i_rx ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                end
            end
            uart_pkg::RX_DATA: begin
                if (bit_end && bit_cnt == WORD_LAST) begin
                    state_next = uart_pkg::RX_STOP;
                end
            end
            uart_pkg::RX_STOP: begin
                if (bit_end) begin
                    if (!i_rx) begin
                        state_next = uart_pkg::RX_ERROR;
                    end else if (stop_cnt == STOP_LAST) begin
                        state_next = uart_pkg::RX_IDLE;
                    end
                end
            end
            uart_pkg::RX_ERROR: begin
                if (bit_end && i_rx) begin
                    state_next = uart_pkg::RX_IDLE;
                end
            end
            default: state_next = uart_pkg::RX_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State, counters and strobes.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state    <= uart_pkg::RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            stop_cnt <= '0;
            o_done   <= 1'b0;
            o_error  <= 1'b0;
        end else begin
            state   <= state_next;
            o_done  <= 1'b0;
            o_error <= 1'b0;
            if (i_tick) begin
                // Restart the count on every state change and bit boundary.
                if (state_next != state || tick_cnt == BIT_LAST) begin
                    tick_cnt <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
            if (state == uart_pkg::RX_START) begin
                bit_cnt  <= '0;
                stop_cnt <= '0;
            end
            if (state == uart_pkg::RX_DATA && bit_end) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (state == uart_pkg::RX_STOP && bit_end) begin
                if (!i_rx) begin
                    o_error <= 1'b1;   // Framing error, byte dropped.
                end else if (stop_cnt == STOP_LAST) begin
                    o_done <= 1'b1;
                end else begin
                    stop_cnt <= stop_cnt + 1'b1;
                end
            end
        end
    end

    // Data shifts in LSB first from the top.
    always_ff @(posedge i_clock) begin
        if (state == uart_pkg::RX_DATA && bit_end) begin
            shift_reg <= {i_rx, shift_reg[`UART_WORD_WIDTH-1:1]};
        end
        if (state == uart_pkg::RX_STOP && bit_end && i_rx && stop_cnt == STOP_LAST) begin
            o_data <= shift_reg;   // Valid with o_done.
        end
    end

    a_state_onehot : assert property (@(posedge i_clock) disable iff (!i_reset)
        $onehot(state))
        else $error("receiver state not one-hot");

    a_done_error_excl : assert property (@(posedge i_clock) disable iff (!i_reset)
        !(o_done && o_error))
        else $error("receiver reports a byte and an error together");

endmodule

`default_nettype wire

// ==== logic/baud_tick_gen.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "uart_defines.svh"

module baud_tick_gen (
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);

    localparam int CNT_W = $clog2(`UART_BAUD_DIVISOR + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_BAUD_DIVISOR - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (count == CNT_LAST) begin
            count  <= '0;   // Wrap and fire.
            o_tick <= 1'b1;
        end else begin
            count  <= count + 1'b1;
            o_tick <= 1'b0;
        end
    end

    // Tick is a single-cycle strobe.
    a_tick_single : assert property (@(posedge i_clock) disable iff (!i_reset)
        o_tick |=> !o_tick)
        else $error("baud tick high for two cycles");

endmodule

`default_nettype wire

// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // ALU opcodes, carried in the low six bits of the opcode byte.
    typedef enum logic [5:0] {
        OP_ADD = 6'b100000,
        OP_SUB = 6'b100010,
        OP_AND = 6'b100100,
        OP_OR  = 6'b100101,
        OP_XOR = 6'b100110,
        OP_NOR = 6'b100111,
        OP_SRA = 6'b000011,
        OP_SRL = 6'b000010
    } alu_op_t;

    // Receiver states, one-hot.
    typedef enum logic [4:0] {
        RX_IDLE  = 5'b00001,
        RX_START = 5'b00010,
        RX_DATA  = 5'b00100,
        RX_STOP  = 5'b01000,
        RX_ERROR = 5'b10000   // Bad stop bit, wait for the line to recover.
    } rx_state_t;

    // Transmitter states.
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    // Frame controller states.
    typedef enum logic [1:0] {CTRL_GET_A, CTRL_GET_B, CTRL_GET_OP, CTRL_SEND} ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/uart_defines.svh ====
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

////////////////////////////////////////////////////////////
// Frame format.
////////////////////////////////////////////////////////////

// Data bits carried by one frame.
`define UART_WORD_WIDTH 8

// Stop bits closing each frame, always high.
`define UART_STOP_BITS 2

////////////////////////////////////////////////////////////
// Bit timing.
////////////////////////////////////////////////////////////

// Oversampling ticks per bit time.
`define UART_TICKS_PER_BIT 16

// Clocks per baud tick.
// 4 keeps simulation short. 163 gives 19200 baud at 50 MHz.
`define UART_BAUD_DIVISOR 4

`endif
